//--- compile.f
rtl/hamming_math_pkg.sv
rtl/ecc_link_pkg.sv
rtl/hamming_block_packer.sv
rtl/hamming_encoder.sv
rtl/hamming_decoder.sv
rtl/ecc_link.sv
sim/ecc_link_tb.sv

//--- rtl/ecc_link.sv
/*
 * Hamming-protected point-to-point link
 * Registered transmit stage feeding the encoder, and a two-stage receive
 * pipeline around the decoder
 */

`default_nettype none

module ecc_link #(
  parameter int  DATA_WIDTH   = 8,
  localparam int PARITY_WIDTH = hamming_math_pkg::get_parity_width(DATA_WIDTH),
  localparam int BLOCK_WIDTH  = hamming_math_pkg::get_block_width(DATA_WIDTH)
) (
  input  wire logic                    clk,
  input  wire logic                    rst_n,
  // Transmit side
  input  wire logic                    tx_valid,
  input  wire logic [DATA_WIDTH-1:0]   tx_data,
  output logic                         tx_done,
  output logic      [BLOCK_WIDTH-1:0]  tx_block,
  output logic      [PARITY_WIDTH-1:0] tx_code,
  // Receive side
  input  wire logic                    rx_valid,
  input  wire logic [BLOCK_WIDTH-1:0]  rx_block,
  output logic                         rx_done,
  output logic      [DATA_WIDTH-1:0]   rx_data,
  output ecc_link_pkg::decode_status_e rx_status,
  output logic      [PARITY_WIDTH-1:0] rx_syndrome
);

  import ecc_link_pkg::*;

  logic [DATA_WIDTH-1:0]   tx_data_q;
  logic [BLOCK_WIDTH-1:0]  rx_block_q;
  logic                    rx_valid_q;
  logic [DATA_WIDTH-1:0]   dec_data;
  logic [PARITY_WIDTH-1:0] dec_syndrome;
  decode_status_e          dec_status;

  // Transmit capture, block and code follow combinationally
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tx_data_q <= '0;
      tx_done   <= 1'b0;
    end else begin
      tx_done <= tx_valid;
      if (tx_valid) begin
        tx_data_q <= tx_data;
      end
    end
  end

  hamming_encoder #(
    .DATA_WIDTH (DATA_WIDTH)
  ) u_encoder (
    .data  (tx_data_q),
    .code  (tx_code),
    .block (tx_block)
  );

  // Receive stage 1, raw block
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rx_block_q <= '0;
      rx_valid_q <= 1'b0;
    end else begin
      rx_valid_q <= rx_valid;
      if (rx_valid) begin
        rx_block_q <= rx_block;
      end
    end
  end

  hamming_decoder #(
    .DATA_WIDTH (DATA_WIDTH)
  ) u_decoder (
    .block    (rx_block_q),
    .data     (dec_data),
    .syndrome (dec_syndrome),
    .status   (dec_status)
  );

  // Receive stage 2, decoded result
  // Results land two edges after rx_valid is sampled
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rx_done     <= 1'b0;
      rx_data     <= '0;
      rx_status   <= status_clean;
      rx_syndrome <= '0;
    end else begin
      rx_done <= rx_valid_q;
      if (rx_valid_q) begin
        rx_data     <= dec_data;
        rx_status   <= dec_status;
        rx_syndrome <= dec_syndrome;
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/ecc_link_pkg.sv
/*
 * ECC link definitions
 * Result classification reported by the Hamming decoder and the link top
 */

`default_nettype none

package ecc_link_pkg;

  // Outcome of one decode
  // status_clean      syndrome zero, data taken as received
  // status_corrected  syndrome inside the real block, that bit flipped back
  // status_invalid    syndrome points into padding or past the block,
  //                   data passed through uncorrected
  typedef enum logic [1:0] {
    status_clean     = 2'b00,
    status_corrected = 2'b01,
    status_invalid   = 2'b10
  } decode_status_e;

endpackage

`default_nettype wire

//--- rtl/hamming_block_packer.sv
/*
 * Hamming block packer
 * Interleaves data and parity bits into one block, parity bit k at index
 * 2^k-1 and data bits in order at every other index
 */

`default_nettype none

module hamming_block_packer #(
  parameter int  DATA_WIDTH   = 11,
  localparam int PARITY_WIDTH = hamming_math_pkg::get_parity_width(DATA_WIDTH),
  localparam int BLOCK_WIDTH  = DATA_WIDTH + PARITY_WIDTH
) (
  input  wire logic [DATA_WIDTH-1:0]   data,
  input  wire logic [PARITY_WIDTH-1:0] code,
  output logic      [BLOCK_WIDTH-1:0]  block
);

  import hamming_math_pkg::*;

  always_comb begin
    int data_index;
    int parity_index;
    data_index   = 0;
    parity_index = 0;
    block        = '0;
    // Walk the block from the low end
    for (int i = 0; i < BLOCK_WIDTH; i++) begin
      if (is_parity_position(i)) begin
        // Next parity bit
        block[i] = code[parity_index];
        parity_index++;
      end else begin
        // Next data bit
        block[i] = data[data_index];
        data_index++;
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/hamming_decoder.sv
/*
 * Hamming decoder
 * Computes the syndrome of a received block, corrects a single flipped bit,
 * extracts the data word and classifies the result, purely combinational
 */

`default_nettype none

module hamming_decoder #(
  parameter int  DATA_WIDTH   = 8,
  localparam int PARITY_WIDTH = hamming_math_pkg::get_parity_width(DATA_WIDTH),
  localparam int BLOCK_WIDTH  = hamming_math_pkg::get_block_width(DATA_WIDTH)
) (
  input  wire logic [BLOCK_WIDTH-1:0] block,
  output logic      [DATA_WIDTH-1:0]  data,
  output logic      [PARITY_WIDTH-1:0] syndrome,
  output ecc_link_pkg::decode_status_e status
);

  import hamming_math_pkg::*;
  import ecc_link_pkg::*;

  localparam int PADDED_BLOCK_WIDTH = get_padded_data_width(PARITY_WIDTH) + PARITY_WIDTH;

  logic [PADDED_BLOCK_WIDTH-1:0] block_padded;
  logic [BLOCK_WIDTH-1:0]        block_fixed;
  logic                          in_range;

  // Zero-extend to the full Hamming length
  always_comb begin
    block_padded                  = '0;
    block_padded[BLOCK_WIDTH-1:0] = block;
  end

  // Syndrome bit k
  // XOR over every one-based index with bit k set, parity bits included
  always_comb begin
    syndrome = '0;
    for (int k = 0; k < PARITY_WIDTH; k++) begin
      for (int i = 0; i < PADDED_BLOCK_WIDTH; i++) begin
        if (((i + 1) & (1 << k)) != 0) begin
          syndrome[k] = syndrome[k] ^ block_padded[i];
        end
      end
    end
  end

  // Syndrome is the one-based index of the bad bit
  // Values past the real block land in padding, which was sent as zero
  assign in_range = (int'(syndrome) <= BLOCK_WIDTH);

  always_comb begin
    if (syndrome == '0) begin
      status = status_clean;
    end else if (in_range) begin
      status = status_corrected;
    end else begin
      status = status_invalid;
    end
  end

  // Flip the single bit the syndrome points at
  // Nothing matches when the syndrome is zero or out of range
  always_comb begin
    block_fixed = block;
    for (int i = 0; i < BLOCK_WIDTH; i++) begin
      if (status == status_corrected && int'(syndrome) == i + 1) begin
        block_fixed[i] = ~block[i];
      end
    end
  end

  // Gather data bits from the non-power-of-two positions, low end first
  // All parity positions fall inside the real block, so exactly
  // DATA_WIDTH data positions remain
  always_comb begin
    int data_index;
    data_index = 0;
    data       = '0;
    for (int i = 0; i < BLOCK_WIDTH; i++) begin
      if (!is_parity_position(i)) begin
        data[data_index] = block_fixed[i];
        data_index++;
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/hamming_encoder.sv
/*
 * Hamming encoder
 * Computes the parity code of a data word and returns the packed block,
 * purely combinational
 */

`default_nettype none

module hamming_encoder #(
  parameter int  DATA_WIDTH   = 8,
  localparam int PARITY_WIDTH = hamming_math_pkg::get_parity_width(DATA_WIDTH),
  localparam int BLOCK_WIDTH  = hamming_math_pkg::get_block_width(DATA_WIDTH)
) (
  input  wire logic [DATA_WIDTH-1:0] data,
  output logic      [PARITY_WIDTH-1:0] code,
  output logic      [BLOCK_WIDTH-1:0]  block
);

  import hamming_math_pkg::*;

  // Full Hamming length for this parity width
  localparam int PADDED_DATA_WIDTH  = get_padded_data_width(PARITY_WIDTH);
  localparam int PADDED_BLOCK_WIDTH = PADDED_DATA_WIDTH + PARITY_WIDTH;

  logic [PADDED_DATA_WIDTH-1:0]  data_padded;
  logic [PADDED_BLOCK_WIDTH-1:0] data_block;
  logic [PADDED_BLOCK_WIDTH-1:0] block_padded;
  logic [PARITY_WIDTH-1:0]       parity;

  // Upper data bits are zero padding
  always_comb begin
    data_padded                 = '0;
    data_padded[DATA_WIDTH-1:0] = data;
  end

  // Data only, parity slots left at zero
  // Keeps the parity sums free of any path back from the parity itself
  hamming_block_packer #(
    .DATA_WIDTH (PADDED_DATA_WIDTH)
  ) u_packer_data (
    .data  (data_padded),
    .code  ('0),
    .block (data_block)
  );

  // Parity bit k covers every one-based index with bit k set
  always_comb begin
    parity = '0;
    for (int k = 0; k < PARITY_WIDTH; k++) begin
      for (int i = 0; i < PADDED_BLOCK_WIDTH; i++) begin
        // Own position excluded
        if (i != (1 << k) - 1 && ((i + 1) & (1 << k)) != 0) begin
          parity[k] = parity[k] ^ data_block[i];
        end
      end
    end
  end

  // Final block with parity in place
  hamming_block_packer #(
    .DATA_WIDTH (PADDED_DATA_WIDTH)
  ) u_packer_out (
    .data  (data_padded),
    .code  (parity),
    .block (block_padded)
  );

  assign code = parity;

  // Padding bits above the real block are always zero, drop them
  assign block = block_padded[BLOCK_WIDTH-1:0];

endmodule

`default_nettype wire

//--- rtl/hamming_math_pkg.sv
/*
 * Hamming code geometry
 * Derives parity width, padded data width and block width from a data width,
 * and identifies the parity positions inside a block
 */

`default_nettype none

package hamming_math_pkg;

  // Smallest p such that a Hamming block of 2^p-1 bits holds the data
  function automatic int get_parity_width(input int data_width);
    int parity_width;
    parity_width = 1;
    while ((1 << parity_width) - parity_width - 1 < data_width) begin
      parity_width++;
    end
    return parity_width;
  endfunction

  // Number of data bits in a full-length block with this many parity bits
  function automatic int get_padded_data_width(input int parity_width);
    return (1 << parity_width) - parity_width - 1;
  endfunction

  // Real block width, before padding to the full Hamming length
  function automatic int get_block_width(input int data_width);
    return data_width + get_parity_width(data_width);
  endfunction

  // Parity sits where the one-based index is a power of two
  // index+1 is a power of two when it shares no bit with index
  function automatic logic is_parity_position(input int index);
    return ((index + 1) & index) == 0;
  endfunction

endpackage

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the ecc_link testbench with Verilator
# Run from the project root

LOG=sim.log

verilator --binary --timing -f compile.f --top-module ecc_link_tb -o ecc_link_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/ecc_link_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
  exit 1
fi
exit 0

//--- sim/ecc_link_tb.sv
/*
 * Testbench for the Hamming-protected link
 * Table-driven encode, loopback, correction and invalid-syndrome checks
 * against a reference Hamming model, plus reset and back-to-back receive
 */

`default_nettype none

module ecc_link_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import ecc_link_pkg::*;

  localparam int TIMEOUT_CYCLES = 20;
  localparam int N_ROWS         = 29;

  logic           clk;
  logic           rst_n;
  logic           tx_valid;
  logic [7:0]     tx_data;
  logic           tx_done;
  logic [11:0]    tx_block;
  logic [3:0]     tx_code;
  logic           rx_valid;
  logic [11:0]    rx_block;
  logic           rx_done;
  logic [7:0]     rx_data;
  decode_status_e rx_status;
  logic [3:0]     rx_syndrome;

  // Stimulus and expected columns
  logic [7:0]     tab_data [N_ROWS];
  int             tab_flip_a [N_ROWS];
  int             tab_flip_b [N_ROWS];
  logic [11:0]    tab_block [N_ROWS];
  logic [3:0]     tab_code [N_ROWS];
  logic [11:0]    tab_mask [N_ROWS];
  logic [3:0]     tab_syn [N_ROWS];
  decode_status_e tab_status [N_ROWS];
  logic [7:0]     tab_rx_data [N_ROWS];

  int          n_rows;
  int          errors;
  int          test_count;
  int          fail_count;
  logic        test_ok;
  logic [31:0] lcg_state;

  ecc_link #(
    .DATA_WIDTH (8)
  ) UUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .tx_valid    (tx_valid),
    .tx_data     (tx_data),
    .tx_done     (tx_done),
    .tx_block    (tx_block),
    .tx_code     (tx_code),
    .rx_valid    (rx_valid),
    .rx_block    (rx_block),
    .rx_done     (rx_done),
    .rx_data     (rx_data),
    .rx_status   (rx_status),
    .rx_syndrome (rx_syndrome)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Full-period 32-bit LCG step
  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Data at non-power-of-two one-based positions
  // Parity at one-based positions 1, 2, 4 and 8
  // Parity equals the XOR of the indices of all set data bits
  function automatic logic [11:0] model_block(input logic [7:0] word);
    logic [11:0] blk;
    logic [3:0]  idx_xor;
    int          d;
    blk     = '0;
    idx_xor = '0;
    d       = 0;
    for (int pos = 1; pos <= 12; pos++) begin
      if ((pos & (pos - 1)) != 0) begin
        blk[pos-1] = word[d];
        if (word[d]) idx_xor ^= 4'(pos);
        d++;
      end
    end
    for (int k = 0; k < 4; k++) begin
      blk[(1 << k) - 1] = idx_xor[k];
    end
    return blk;
  endfunction

  function automatic logic [7:0] extract_data(input logic [11:0] blk);
    logic [7:0] word;
    int         d;
    word = '0;
    d    = 0;
    for (int pos = 1; pos <= 12; pos++) begin
      if ((pos & (pos - 1)) != 0) begin
        word[d] = blk[pos-1];
        d++;
      end
    end
    return word;
  endfunction

  // Adds one row with expected values worked out from the flips
  task automatic add_row(input logic [7:0] word, input int fa, input int fb);
    logic [11:0] blk;
    logic [11:0] mask;
    logic [11:0] rcv;
    logic [3:0]  syn;
    blk  = model_block(word);
    mask = '0;
    syn  = '0;
    if (fa >= 0) begin
      mask[fa] = 1'b1;
      syn ^= 4'(fa + 1);
    end
    if (fb >= 0) begin
      mask[fb] = 1'b1;
      syn ^= 4'(fb + 1);
    end
    rcv = blk ^ mask;
    tab_data[n_rows]   = word;
    tab_flip_a[n_rows] = fa;
    tab_flip_b[n_rows] = fb;
    tab_block[n_rows]  = blk;
    tab_code[n_rows]   = {blk[7], blk[3], blk[1], blk[0]};
    tab_mask[n_rows]   = mask;
    tab_syn[n_rows]    = syn;
    if (syn == 4'd0) begin
      tab_status[n_rows] = status_clean;
    end else if (syn <= 4'd12) begin
      tab_status[n_rows] = status_corrected;
      rcv[int'(syn) - 1] = ~rcv[int'(syn) - 1];
    end else begin
      // Syndrome points past the block so data stays as received
      tab_status[n_rows] = status_invalid;
    end
    tab_rx_data[n_rows] = extract_data(rcv);
    n_rows++;
  endtask

  task automatic fill_table();
    logic [7:0] word;
    int         flip;
    n_rows = 0;
    // Clean words
    add_row(8'h00, -1, -1);
    add_row(8'hff, -1, -1);
    add_row(8'ha5, -1, -1);
    add_row(8'h5a, -1, -1);
    // A single flip at every block position
    for (int pos = 0; pos < 12; pos++) begin
      add_row(8'h3c + 8'(pos * 37), pos, -1);
    end
    // Double flips whose index XOR lands beyond the block
    add_row(8'h96, 5, 8);
    add_row(8'h01, 3, 9);
    add_row(8'h80, 6, 7);
    add_row(8'h7e, 11, 0);
    add_row(8'hc3, 10, 3);
    // Random words with one random flip
    lcg_state = 32'hfaf0;
    for (int i = 0; i < 8; i++) begin
      lcg_state = lcg_next(lcg_state);
      word      = lcg_state[23:16];
      flip      = int'(lcg_state[15:8] % 8'd12);
      add_row(word, flip, -1);
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("mismatch at %0d ns: %s actual %0h expected %0h",
               $time, name, actual, expected);
      errors++;
      test_ok = 1'b0;
    end
  endtask

  task automatic report_test(input string name);
    test_count++;
    if (test_ok) begin
      $display("test %0d %s: ok", test_count, name);
    end else begin
      fail_count++;
      $display("test %0d %s: FAILED", test_count, name);
    end
  endtask

  // Starts on a falling edge and returns on the falling edge after tx_done
  task automatic send_word(input logic [7:0] word, output int latency);
    int cycles;
    tx_data  = word;
    tx_valid = 1'b1;
    @(negedge clk);
    tx_valid = 1'b0;
    cycles   = 1;
    while (!tx_done && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      cycles++;
    end
    if (!tx_done) begin
      $display("timeout at %0d ns: tx_done did not rise within %0d cycles",
               $time, TIMEOUT_CYCLES);
      errors++;
      test_ok = 1'b0;
    end
    latency = cycles;
  endtask

  task automatic receive_block(input logic [11:0] blk, output int latency);
    int cycles;
    rx_block = blk;
    rx_valid = 1'b1;
    @(negedge clk);
    rx_valid = 1'b0;
    cycles   = 1;
    while (!rx_done && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      cycles++;
    end
    if (!rx_done) begin
      $display("timeout at %0d ns: rx_done did not rise within %0d cycles",
               $time, TIMEOUT_CYCLES);
      errors++;
      test_ok = 1'b0;
    end
    latency = cycles;
  endtask

  task automatic check_rx(input int r);
    check_value("rx_data", 32'(rx_data), 32'(tab_rx_data[r]));
    check_value("rx_syndrome", 32'(rx_syndrome), 32'(tab_syn[r]));
    check_value("rx_status", 32'(rx_status), 32'(tab_status[r]));
  endtask

  // Encodes the word and loops the DUT's own block back with the row's flips
  task automatic run_row(input int r);
    int latency;
    test_ok = 1'b1;
    send_word(tab_data[r], latency);
    check_value("tx_latency", 32'(latency), 32'd1);
    check_value("tx_block", 32'(tx_block), 32'(tab_block[r]));
    check_value("tx_code", 32'(tx_code), 32'(tab_code[r]));
    receive_block(tx_block ^ tab_mask[r], latency);
    check_value("rx_latency", 32'(latency), 32'd2);
    // tx_done is a single-cycle strobe
    check_value("tx_done", 32'(tx_done), 32'd0);
    check_rx(r);
    report_test($sformatf("row %0d data %h flips %0d %0d", r, tab_data[r],
                          tab_flip_a[r], tab_flip_b[r]));
  endtask

  // Three receive words on consecutive cycles give their results in order
  task automatic run_back_to_back();
    int rows [3];
    int got;
    int cycles;
    rows     = '{1, 9, 16};
    test_ok  = 1'b1;
    rx_block = tab_block[rows[0]] ^ tab_mask[rows[0]];
    rx_valid = 1'b1;
    got      = 0;
    cycles   = 0;
    while (got < 3 && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      cycles++;
      if (rx_done) begin
        check_value("rx_latency", 32'(cycles - got), 32'd2);
        check_rx(rows[got]);
        got++;
      end
      if (cycles < 3) begin
        rx_block = tab_block[rows[cycles]] ^ tab_mask[rows[cycles]];
      end else begin
        rx_valid = 1'b0;
      end
    end
    if (got < 3) begin
      $display("timeout at %0d ns: only %0d of 3 back-to-back results arrived",
               $time, got);
      errors++;
      test_ok = 1'b0;
    end
    report_test("back-to-back receive");
  endtask

  initial begin
    rst_n      = 1'b0;
    tx_valid   = 1'b0;
    tx_data    = '0;
    rx_valid   = 1'b0;
    rx_block   = '0;
    errors     = 0;
    test_count = 0;
    fail_count = 0;
    fill_table();
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    // Strobes and outputs at their reset values
    test_ok = 1'b1;
    check_value("tx_done", 32'(tx_done), 32'd0);
    check_value("rx_done", 32'(rx_done), 32'd0);
    check_value("rx_status", 32'(rx_status), 32'(status_clean));
    check_value("rx_data", 32'(rx_data), 32'd0);
    report_test("reset state");
    for (int r = 0; r < n_rows; r++) begin
      run_row(r);
    end
    run_back_to_back();
    $display("%0d tests run, %0d failed, %0d errors", test_count, fail_count, errors);
    if (errors == 0 && fail_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
